// ==== mcu_irq_pkg.sv ====
package mcu_irq_pkg;

    ////////////////////////////////////////////////////////////
    // Widths that carry a meaning
    ////////////////////////////////////////////////////////////
    typedef logic [7:0]  cfg_addr_t;
    typedef logic [7:0]  cfg_data_t;
    typedef logic [15:0] timer_count_t;
    typedef logic [2:0]  prescale_sel_t;
    typedef logic [7:0]  vector_t;
    typedef logic [1:0]  credit_t;

    // Sense control of the external pin
    typedef enum logic [1:0] {
        SENSE_NONE   = 2'd0,
        SENSE_RISE   = 2'd1,
        SENSE_FALL   = 2'd2,
        SENSE_CHANGE = 2'd3
    } exti_sense_e;

    typedef enum logic {
        IRQ_IDLE  = 1'b0,
        IRQ_ISSUE = 1'b1
    } irq_state_e;

    ////////////////////////////////////////////////////////////
    // Reserved register map and defaults
    ////////////////////////////////////////////////////////////
    localparam cfg_addr_t    ADDR_EXTI_CFG     = 8'h0D;
    localparam cfg_addr_t    ADDR_TIMER_CFG    = 8'h0E;
    localparam cfg_addr_t    ADDR_TIMER_LIM_H  = 8'h0F;
    localparam cfg_addr_t    ADDR_TIMER_LIM_L  = 8'h10;

    localparam cfg_data_t    EXTI_CFG_DEFAULT  = 8'h00;
    localparam cfg_data_t    TIMER_CFG_DEFAULT = 8'h00;
    localparam timer_count_t TIMER_LIM_DEFAULT = 16'hFFFF;

    // Handler entry points in program memory
    localparam vector_t      EXTI_VECTOR       = 8'h40;
    localparam vector_t      TIMER_VECTOR      = 8'h80;

    localparam credit_t      IRQ_CREDITS       = 2'd2;

    localparam int DEBOUNCE_CYCLES    = 16;
    localparam int DEBOUNCE_CNT_WIDTH = $clog2(DEBOUNCE_CYCLES);
    // Largest prescaler count is 2**7 - 1
    localparam int PRESCALE_CNT_WIDTH = 7;

endpackage

// ==== periph_cfg_if.sv ====
`timescale 1ns/1ns

interface periph_cfg_if;
    import mcu_irq_pkg::*;

    // External interrupt fields
    logic          exti_enable;
    exti_sense_e   exti_sense;
    logic          exti_debounce;

    // Timer interrupt fields
    logic          timer_enable;
    logic          timer_option;
    prescale_sel_t timer_prescale;
    timer_count_t  timer_limit;

    modport src (
        output exti_enable, exti_sense, exti_debounce,
        output timer_enable, timer_option, timer_prescale, timer_limit
    );

    modport exti (input exti_enable, exti_sense, exti_debounce);

    modport timer (input timer_enable, timer_option, timer_prescale, timer_limit);

endinterface

// ==== cfg_regs.sv ====
`timescale 1ns/1ns

module cfg_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cfg_wr_en,
    input  mcu_irq_pkg::cfg_addr_t cfg_addr,
    input  mcu_irq_pkg::cfg_data_t cfg_wr_data,
    output mcu_irq_pkg::cfg_data_t cfg_rd_data,
    periph_cfg_if.src              cfg
);
    import mcu_irq_pkg::*;

    cfg_data_t exti_cfg;
    cfg_data_t timer_cfg;
    cfg_data_t timer_lim_h;
    cfg_data_t timer_lim_l;

    ////////////////////////////////////////////////////////////
    // Register write
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            exti_cfg    <= EXTI_CFG_DEFAULT;
            timer_cfg   <= TIMER_CFG_DEFAULT;
            timer_lim_h <= TIMER_LIM_DEFAULT[7:0];
            timer_lim_l <= TIMER_LIM_DEFAULT[15:8];
        end else if (cfg_wr_en) begin
            case (cfg_addr)
                ADDR_EXTI_CFG:    exti_cfg    <= cfg_wr_data;
                ADDR_TIMER_CFG:   timer_cfg   <= cfg_wr_data;
                ADDR_TIMER_LIM_H: timer_lim_h <= cfg_wr_data;
                ADDR_TIMER_LIM_L: timer_lim_l <= cfg_wr_data;
                default:          ;
            endcase
        end
    end

    // Unmapped addresses read back as zero
    always_comb begin
        case (cfg_addr)
            ADDR_EXTI_CFG:    cfg_rd_data = exti_cfg;
            ADDR_TIMER_CFG:   cfg_rd_data = timer_cfg;
            ADDR_TIMER_LIM_H: cfg_rd_data = timer_lim_h;
            ADDR_TIMER_LIM_L: cfg_rd_data = timer_lim_l;
            default:          cfg_rd_data = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Field split
    ////////////////////////////////////////////////////////////
    assign cfg.exti_enable    = exti_cfg[7];
    assign cfg.exti_sense     = exti_sense_e'(exti_cfg[6:5]);
    assign cfg.exti_debounce  = exti_cfg[4];

    assign cfg.timer_enable   = timer_cfg[7];
    assign cfg.timer_option   = timer_cfg[6];
    assign cfg.timer_prescale = timer_cfg[2:0];

    // The byte at 0x10 is the upper half of the limit
    assign cfg.timer_limit    = {timer_lim_l, timer_lim_h};

endmodule

// ==== exti_detector.sv ====
`timescale 1ns/1ns

module exti_detector (
    input  logic       clk,
    input  logic       rst,
    input  logic       exti_pin,
    periph_cfg_if.exti cfg,
    output logic       exti_req
);
    import mcu_irq_pkg::*;

    logic                          pin_meta;
    logic                          pin_sync;
    logic                          level;
    logic                          level_next;
    logic                          settled;
    logic [DEBOUNCE_CNT_WIDTH-1:0] db_cnt;
    logic                          rise;
    logic                          fall;
    logic                          hit;

    // Two flop synchronizer
    always_ff @(posedge clk) begin
        if (rst) begin
            pin_meta <= 1'b0;
            pin_sync <= 1'b0;
        end else begin
            pin_meta <= exti_pin;
            pin_sync <= pin_meta;
        end
    end

    ////////////////////////////////////////////////////////////
    // Debounce filter
    ////////////////////////////////////////////////////////////
    assign settled = (db_cnt == DEBOUNCE_CNT_WIDTH'(DEBOUNCE_CYCLES - 1));

    always_comb begin
        if (!cfg.exti_debounce) begin
            level_next = pin_sync;
        end else if (pin_sync != level && settled) begin
            level_next = pin_sync;
        end else begin
            level_next = level;
        end
    end

    // Counts cycles the new level has held
    always_ff @(posedge clk) begin
        if (rst) begin
            db_cnt <= '0;
        end else if (!cfg.exti_debounce || pin_sync == level || settled) begin
            db_cnt <= '0;
        end else begin
            db_cnt <= db_cnt + 1'b1;
        end
    end

    // Edge against the accepted level
    assign rise = !level && level_next;
    assign fall = level && !level_next;

    always_comb begin
        case (cfg.exti_sense)
            SENSE_RISE:   hit = rise;
            SENSE_FALL:   hit = fall;
            SENSE_CHANGE: hit = rise || fall;
            default:      hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            level    <= 1'b0;
            exti_req <= 1'b0;
        end else begin
            level    <= level_next;
            exti_req <= cfg.exti_enable && hit;
        end
    end

endmodule

// ==== timer_irq_gen.sv ====
`timescale 1ns/1ns

module timer_irq_gen (
    input  logic        clk,
    input  logic        rst,
    periph_cfg_if.timer cfg,
    output logic        timer_req
);
    import mcu_irq_pkg::*;

    logic [PRESCALE_CNT_WIDTH-1:0] presc_cnt;
    logic [PRESCALE_CNT_WIDTH-1:0] presc_max;
    logic                          tick;
    timer_count_t                  count;
    logic                          at_limit;
    logic                          fire;

    ////////////////////////////////////////////////////////////
    // Prescaler
    ////////////////////////////////////////////////////////////
    // Tick every 2**sel cycles
    assign presc_max = PRESCALE_CNT_WIDTH'((1 << cfg.timer_prescale) - 1);
    assign tick      = (presc_cnt == presc_max);

    // Option 1 compares against the limit, option 0 waits for wrap
    always_comb begin
        if (cfg.timer_option) begin
            at_limit = (count == cfg.timer_limit);
        end else begin
            at_limit = (count == '1);
        end
    end

    assign fire = tick && at_limit;

    ////////////////////////////////////////////////////////////
    // Counter and request
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            presc_cnt <= '0;
            count     <= '0;
            timer_req <= 1'b0;
        end else if (!cfg.timer_enable) begin
            // Stopped timer holds at zero
            presc_cnt <= '0;
            count     <= '0;
            timer_req <= 1'b0;
        end else begin
            timer_req <= fire;
            if (tick) begin
                presc_cnt <= '0;
            end else begin
                presc_cnt <= presc_cnt + 1'b1;
            end
            if (fire && cfg.timer_option) begin
                count <= '0;
            end else if (tick) begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

// ==== irq_controller.sv ====
`timescale 1ns/1ns

module irq_controller (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 exti_req,
    input  logic                 timer_req,
    input  logic                 reti,
    output logic                 irq_valid,
    output mcu_irq_pkg::vector_t irq_vector
);
    import mcu_irq_pkg::*;

    irq_state_e state;
    credit_t    credits;
    logic       exti_pend;
    logic       timer_pend;
    logic       exti_live;
    logic       timer_live;
    logic       grant;
    logic       grant_exti;
    logic       grant_timer;
    logic       refund;

    ////////////////////////////////////////////////////////////
    // Arbitration
    ////////////////////////////////////////////////////////////
    // Request pulses count as pending in their own cycle
    assign exti_live  = exti_pend || exti_req;
    assign timer_live = timer_pend || timer_req;

    // Only from idle, and only with a credit in hand
    assign grant       = (state == IRQ_IDLE) && (credits != '0) && (exti_live || timer_live);
    assign grant_exti  = grant && exti_live;
    assign grant_timer = grant && !exti_live;

    // reti on a full pool is dropped
    assign refund = reti && (credits != IRQ_CREDITS);

    assign irq_valid = (state == IRQ_ISSUE);

    // Repeated requests merge in the pending latches
    always_ff @(posedge clk) begin
        if (rst) begin
            exti_pend  <= 1'b0;
            timer_pend <= 1'b0;
        end else begin
            exti_pend  <= exti_live && !grant_exti;
            timer_pend <= timer_live && !grant_timer;
        end
    end

    // ISSUE lasts one cycle, so a second source waits a cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IRQ_IDLE;
        end else begin
            case (state)
                IRQ_IDLE: begin
                    if (grant) begin
                        state <= IRQ_ISSUE;
                    end
                end
                IRQ_ISSUE: state <= IRQ_IDLE;
                default:   state <= IRQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            irq_vector <= grant_exti ? EXTI_VECTOR : TIMER_VECTOR;
        end
    end

    ////////////////////////////////////////////////////////////
    // Credit pool
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= IRQ_CREDITS;
        end else begin
            case ({grant, refund})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

// ==== mcu_irq_unit.sv ====
`timescale 1ns/1ns

module mcu_irq_unit (
    input  logic                   clk,
    input  logic                   rst,
    // Configuration bus
    input  logic                   cfg_wr_en,
    input  mcu_irq_pkg::cfg_addr_t cfg_addr,
    input  mcu_irq_pkg::cfg_data_t cfg_wr_data,
    output mcu_irq_pkg::cfg_data_t cfg_rd_data,
    // External interrupt pin
    input  logic                   exti_pin,
    // Core side
    output logic                   irq_valid,
    output mcu_irq_pkg::vector_t   irq_vector,
    input  logic                   reti
);

    logic exti_req;
    logic timer_req;

    // Decoded configuration fields
    periph_cfg_if cfg_bus ();

    cfg_regs i_cfg_regs (
        .clk         (clk),
        .rst         (rst),
        .cfg_wr_en   (cfg_wr_en),
        .cfg_addr    (cfg_addr),
        .cfg_wr_data (cfg_wr_data),
        .cfg_rd_data (cfg_rd_data),
        .cfg         (cfg_bus.src)
    );

    exti_detector i_exti_detector (
        .clk      (clk),
        .rst      (rst),
        .exti_pin (exti_pin),
        .cfg      (cfg_bus.exti),
        .exti_req (exti_req)
    );

    timer_irq_gen i_timer_irq_gen (
        .clk       (clk),
        .rst       (rst),
        .cfg       (cfg_bus.timer),
        .timer_req (timer_req)
    );

    irq_controller i_irq_controller (
        .clk        (clk),
        .rst        (rst),
        .exti_req   (exti_req),
        .timer_req  (timer_req),
        .reti       (reti),
        .irq_valid  (irq_valid),
        .irq_vector (irq_vector)
    );

endmodule

// ==== mcu_irq_unit_sva.sv ====
`timescale 1ns/1ns

module mcu_irq_unit_sva (
    input logic                 clk,
    input logic                 rst,
    input logic                 irq_valid,
    input mcu_irq_pkg::credit_t credits
);
    import mcu_irq_pkg::*;

    ////////////////////////////////////////////////////////////
    // Credit protocol
    ////////////////////////////////////////////////////////////
    // Pool before the grant must have held a credit
    assert property (@(posedge clk) disable iff (rst)
        $rose(irq_valid) |-> $past(credits) != '0)
        else $error("irq_valid rose with no credit in the pool");

    assert property (@(posedge clk) disable iff (rst)
        credits <= IRQ_CREDITS)
        else $error("credit pool above its size");

    // Single cycle vector pulse
    assert property (@(posedge clk) disable iff (rst)
        irq_valid |=> !irq_valid)
        else $error("irq_valid held longer than one cycle");

endmodule

bind irq_controller mcu_irq_unit_sva i_mcu_irq_unit_sva (
    .clk       (clk),
    .rst       (rst),
    .irq_valid (irq_valid),
    .credits   (credits)
);

// ==== tb_mcu_irq_unit.sv ====
`timescale 1ns/1ns

module tb_mcu_irq_unit;
    import mcu_irq_pkg::*;

    typedef struct packed {
        logic      wr;
        logic      rnd;
        cfg_addr_t addr;
        cfg_data_t data;
        cfg_data_t exp;
    } row_t;

    localparam int NUM_ROWS = 14;

    logic      clk;
    logic      rst;
    logic      cfg_wr_en;
    cfg_addr_t cfg_addr;
    cfg_data_t cfg_wr_data;
    cfg_data_t cfg_rd_data;
    logic      exti_pin;
    logic      irq_valid;
    vector_t   irq_vector;
    logic      reti = 1'b0;

    int        errors = 0;
    int        tests = 0;
    int        err_mark = 0;
    int        seed = 32'hb1a9_d4b6;
    int        rnd_word;
    int        cycle = 0;
    int        reti_req = 0;
    int        reti_done = 0;
    logic      auto_reti = 1'b0;
    logic      seen_valid = 1'b0;
    row_t      row;
    cfg_data_t rd;
    vector_t   vec_q[$];
    int        cyc_q[$];

    // Row fields are write, random data, address, write data and expected read-back
    // Defaults come first
    // Addresses 0x0C and 0x11 are unmapped
    row_t rows [NUM_ROWS] = '{
        '{1'b0, 1'b0, 8'h0D, 8'h00, 8'h00},
        '{1'b0, 1'b0, 8'h0E, 8'h00, 8'h00},
        '{1'b0, 1'b0, 8'h0F, 8'h00, 8'hFF},
        '{1'b0, 1'b0, 8'h10, 8'h00, 8'hFF},
        '{1'b0, 1'b0, 8'h0C, 8'h00, 8'h00},
        '{1'b0, 1'b0, 8'h11, 8'h00, 8'h00},
        '{1'b1, 1'b0, 8'h0D, 8'hA5, 8'hA5},
        '{1'b1, 1'b0, 8'h0E, 8'h3C, 8'h3C},
        '{1'b1, 1'b1, 8'h0F, 8'h00, 8'h00},
        '{1'b1, 1'b1, 8'h10, 8'h00, 8'h00},
        '{1'b1, 1'b0, 8'h0C, 8'h77, 8'h00},
        '{1'b1, 1'b0, 8'h11, 8'h5A, 8'h00},
        // Mapped registers keep their values after unmapped writes
        '{1'b0, 1'b0, 8'h0D, 8'h00, 8'hA5},
        '{1'b0, 1'b0, 8'h0E, 8'h00, 8'h3C}
    };

    mcu_irq_unit i_mcu_irq_unit (
        .clk         (clk),
        .rst         (rst),
        .cfg_wr_en   (cfg_wr_en),
        .cfg_addr    (cfg_addr),
        .cfg_wr_data (cfg_wr_data),
        .cfg_rd_data (cfg_rd_data),
        .exti_pin    (exti_pin),
        .irq_valid   (irq_valid),
        .irq_vector  (irq_vector),
        .reti        (reti)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Core model
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Log every issued vector with its cycle
    always @(negedge clk) begin
        seen_valid <= irq_valid;
        if (irq_valid) begin
            vec_q.push_back(irq_vector);
            cyc_q.push_back(cycle);
        end
    end

    // reti either answers a vector or serves an explicit request
    always @(posedge clk) begin
        if (reti_done != reti_req) begin
            reti      <= 1'b1;
            reti_done <= reti_done + 1;
        end else begin
            reti <= auto_reti && seen_valid;
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    task automatic check_value(input int got, input int exp, input string what);
        if (got != exp) begin
            errors++;
            $display("FAILED at %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic write_reg(input cfg_addr_t addr, input cfg_data_t data);
        @(posedge clk);
        cfg_wr_en   <= 1'b1;
        cfg_addr    <= addr;
        cfg_wr_data <= data;
        @(posedge clk);
        cfg_wr_en   <= 1'b0;
    endtask

    task automatic read_reg(input cfg_addr_t addr, output cfg_data_t data);
        @(posedge clk);
        cfg_addr <= addr;
        @(negedge clk);
        data = cfg_rd_data;
    endtask

    task automatic set_pin(input logic value);
        @(posedge clk);
        exti_pin <= value;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic clear_log();
        @(posedge clk);
        vec_q.delete();
        cyc_q.delete();
    endtask

    task automatic wait_vectors(input int n, input int limit);
        int waited;
        waited = 0;
        while (vec_q.size() < n && waited < limit) begin
            @(posedge clk);
            waited++;
        end
        if (vec_q.size() < n) begin
            errors++;
            $display("Timeout: vector %0d did not arrive within %0d cycles", n, limit);
        end
    endtask

    task automatic return_credit();
        int waited;
        waited = 0;
        @(negedge clk);
        reti_req++;
        while (reti_done != reti_req && waited < 10) begin
            @(posedge clk);
            waited++;
        end
        if (reti_done != reti_req) begin
            errors++;
            $display("Timeout: the reti pulse was never driven");
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == err_mark) begin
            $display("Test %0d %s: passed", tests, name);
        end else begin
            $display("Test %0d %s: %0d errors", tests, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    ////////////////////////////////////////////////////////////
    // Scenarios
    ////////////////////////////////////////////////////////////
    initial begin
        rst         = 1'b1;
        cfg_wr_en   = 1'b0;
        cfg_addr    = '0;
        cfg_wr_data = '0;
        exti_pin    = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // Register defaults and read-back
        @(negedge clk);
        check_value(int'(irq_valid), 0, "irq_valid after reset");
        for (int i = 0; i < NUM_ROWS; i++) begin
            row = rows[i];
            if (row.rnd) begin
                rnd_word = $random(seed);
                row.data = rnd_word[7:0];
                row.exp  = rnd_word[7:0];
            end
            if (row.wr) begin
                write_reg(row.addr, row.data);
            end
            read_reg(row.addr, rd);
            check_value(int'(rd), int'(row.exp), $sformatf("read-back of 0x%02h", row.addr));
        end
        write_reg(8'h0D, 8'h00);
        end_test("registers");

        // Timer at limit 9 and prescaler 1 gives a 20 cycle period
        @(negedge clk);
        auto_reti = 1'b1;
        write_reg(8'h0F, 8'h09);
        write_reg(8'h10, 8'h00);
        clear_log();
        write_reg(8'h0E, 8'hC1);
        wait_vectors(4, 120);
        for (int i = 0; i < 4; i++) begin
            check_value(int'(vec_q[i]), 'h80, "timer vector");
            if (i > 0) begin
                check_value(cyc_q[i] - cyc_q[i-1], 20, "timer vector spacing");
            end
        end
        write_reg(8'h0E, 8'h00);
        idle(10);
        end_test("timer limit mode");

        // Sense rise and then sense change
        write_reg(8'h0D, 8'hA0);
        clear_log();
        set_pin(1'b1);
        wait_vectors(1, 10);
        idle(10);
        set_pin(1'b0);
        idle(20);
        check_value(vec_q.size(), 1, "vectors for rise sense");
        check_value(int'(vec_q[0]), 'h40, "exti vector");
        write_reg(8'h0D, 8'hE0);
        clear_log();
        set_pin(1'b1);
        wait_vectors(1, 10);
        set_pin(1'b0);
        wait_vectors(2, 10);
        idle(10);
        check_value(vec_q.size(), 2, "vectors for change sense");
        check_value(int'(vec_q[0]), 'h40, "exti vector on rise");
        check_value(int'(vec_q[1]), 'h40, "exti vector on fall");
        end_test("exti sense");

        // Debounce with rise sense
        write_reg(8'h0D, 8'hB0);
        clear_log();
        set_pin(1'b1);
        idle(9);
        set_pin(1'b0);
        idle(30);
        check_value(vec_q.size(), 0, "vectors after short pulse");
        set_pin(1'b1);
        wait_vectors(1, 40);
        idle(20);
        set_pin(1'b0);
        idle(40);
        check_value(vec_q.size(), 1, "vectors after held level");
        check_value(int'(vec_q[0]), 'h40, "debounced exti vector");
        end_test("debounce");

        // No reti while the timer fires 5 times
        @(negedge clk);
        auto_reti = 1'b0;
        write_reg(8'h0D, 8'hA0);
        clear_log();
        write_reg(8'h0E, 8'hC1);
        idle(110);
        check_value(vec_q.size(), 2, "vectors without reti");
        return_credit();
        wait_vectors(3, 30);
        idle(30);
        check_value(vec_q.size(), 3, "vectors after one reti");
        check_value(int'(vec_q[2]), 'h80, "released timer vector");
        // Timer is pending again and now the pin as well
        set_pin(1'b1);
        idle(10);
        write_reg(8'h0E, 8'h00);
        check_value(vec_q.size(), 3, "vectors with both sources pending");
        return_credit();
        wait_vectors(4, 20);
        idle(10);
        check_value(vec_q.size(), 4, "vectors after first reti");
        check_value(int'(vec_q[3]), 'h40, "priority winner");
        return_credit();
        wait_vectors(5, 20);
        check_value(int'(vec_q[4]), 'h80, "vector after priority winner");
        end_test("back-pressure and priority");

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== mcu_irq_unit.f ====
mcu_irq_pkg.sv
periph_cfg_if.sv
cfg_regs.sv
exti_detector.sv
timer_irq_gen.sv
irq_controller.sv
mcu_irq_unit.sv
mcu_irq_unit_sva.sv
tb_mcu_irq_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ns \
        --top-module tb_mcu_irq_unit -f mcu_irq_unit.f; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_mcu_irq_unit)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation binary exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1
